// ==== hacd.f ====
rtl/hacd_pkg.sv
rtl/hawk_cpu_stall_rd.sv
rtl/hawk_att_table.sv
rtl/hawk_ctrl.sv
rtl/hacd_top.sv
verification/hacd_properties.sv
verification/hacd_checker.sv
verification/tb_hacd.sv

// ==== verification/tb_hacd.sv ====
// Testbench for the page remapping read bridge
// Clock, reset, table programming, CPU read stimulus, memory responder
// and the reference translation model

`timescale 1ns/1ps

module tb_hacd;

    localparam int ID_WIDTH    = 4;
    localparam int DATA_WIDTH  = 64;
    localparam int ATT_ENTRIES = 16;
    localparam int IDX_W       = $clog2(ATT_ENTRIES);
    localparam int WAIT_LIMIT  = 200;

    logic                  clk;
    logic                  rst;
    logic                  hawk_enable;
    hacd_pkg::att_wr_t     att_wr;
    hacd_pkg::miss_cnt_t   att_miss_count;
    logic [ID_WIDTH-1:0]   s_axi_arid;
    logic [ID_WIDTH-1:0]   s_axi_rid;
    logic [ID_WIDTH-1:0]   m_axi_arid;
    logic [ID_WIDTH-1:0]   m_axi_rid;
    hacd_pkg::addr_t       s_axi_araddr;
    hacd_pkg::addr_t       m_axi_araddr;
    hacd_pkg::addr_t       exp_araddr;
    hacd_pkg::ar_attr_t    s_axi_arattr;
    hacd_pkg::ar_attr_t    m_axi_arattr;
    logic [DATA_WIDTH-1:0] s_axi_rdata;
    logic [DATA_WIDTH-1:0] m_axi_rdata;
    logic [1:0]            s_axi_rresp;
    logic [1:0]            m_axi_rresp;
    logic                  s_axi_arvalid;
    logic                  s_axi_arready;
    logic                  s_axi_rlast;
    logic                  s_axi_rvalid;
    logic                  s_axi_rready;
    logic                  m_axi_arvalid;
    logic                  m_axi_arready;
    logic                  m_axi_rlast;
    logic                  m_axi_rvalid;
    logic                  m_axi_rready;
    hacd_pkg::miss_cnt_t   exp_miss_count;
    int                    error_count;
    int                    seed;
    bit                    timed_out;

    // Shadow of the programmed table
    logic            shadow_valid [ATT_ENTRIES];
    hacd_pkg::page_t shadow_page [ATT_ENTRIES];
    hacd_pkg::page_t shadow_ppa [ATT_ENTRIES];

    // Bursts accepted by the memory model
    hacd_pkg::addr_t     mem_addr_q[$];
    logic [ID_WIDTH-1:0] mem_id_q[$];
    logic [7:0]          mem_len_q[$];
    int                  mem_beat;

    hacd_top #(
        .ID_WIDTH    (ID_WIDTH),
        .DATA_WIDTH  (DATA_WIDTH),
        .ATT_ENTRIES (ATT_ENTRIES)
    ) i_dut (.*);

    hacd_checker #(
        .ID_WIDTH   (ID_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) i_checker (.*);

    function automatic logic page_hit(input hacd_pkg::page_t page);
        logic [IDX_W-1:0] idx;
        idx = page[IDX_W-1:0];
        return shadow_valid[idx] && (shadow_page[idx] == page);
    endfunction

    // Expected memory address with the page swapped on an enabled hit
    function automatic hacd_pkg::addr_t translate_addr(input hacd_pkg::addr_t addr,
                                                       input logic enable);
        hacd_pkg::page_t page;
        page = addr[hacd_pkg::ADDR_WIDTH-1:hacd_pkg::PAGE_SHIFT];
        if (enable && page_hit(page)) begin
            return {shadow_ppa[page[IDX_W-1:0]], addr[hacd_pkg::PAGE_SHIFT-1:0]};
        end
        return addr;
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic program_entry(input int idx, input logic entry_valid);
        logic [31:0]     rnd;
        hacd_pkg::page_t page;
        rnd = $random(seed);
        page = rnd[hacd_pkg::PAGE_WIDTH-1:0];
        page[IDX_W-1:0] = idx[IDX_W-1:0];
        rnd = $random(seed);
        att_wr.valid = 1'b1;
        att_wr.entry_valid = entry_valid;
        att_wr.page = page;
        att_wr.ppa = rnd[hacd_pkg::PAGE_WIDTH-1:0];
        shadow_valid[idx] = entry_valid;
        shadow_page[idx] = page;
        shadow_ppa[idx] = att_wr.ppa;
        @(posedge clk);
        #1;
        att_wr.valid = 1'b0;
    endtask

    task automatic send_read(input logic [ID_WIDTH-1:0] id, input hacd_pkg::addr_t addr,
                             input hacd_pkg::ar_attr_t attr);
        int waited;
        if (!timed_out) begin
            s_axi_arid = id;
            s_axi_araddr = addr;
            s_axi_arattr = attr;
            s_axi_arvalid = 1'b1;
            exp_araddr = translate_addr(addr, hawk_enable);
            if (hawk_enable && !page_hit(addr[hacd_pkg::ADDR_WIDTH-1:hacd_pkg::PAGE_SHIFT])) begin
                exp_miss_count++;
            end
            waited = 0;
            @(posedge clk);
            while (!s_axi_arready && !timed_out) begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    timed_out = 1'b1;
                    $display("Timeout at %0t waiting for s_axi_arready", $time);
                end else begin
                    @(posedge clk);
                end
            end
            #1;
            s_axi_arvalid = 1'b0;
        end
    endtask

    task automatic send_batch(input int count);
        logic [31:0]        rnd;
        logic [31:0]        rnd_low;
        logic [31:0]        rnd_attr;
        logic [IDX_W-1:0]   idx;
        hacd_pkg::page_t    page;
        hacd_pkg::ar_attr_t attr;
        for (int n = 0; n < count; n++) begin
            rnd = $random(seed);
            rnd_low = $random(seed);
            rnd_attr = $random(seed);
            idx = rnd[IDX_W-1:0];
            // Programmed page, same index with another tag, or any page
            case (rnd[5:4])
                2'd0, 2'd1: page = shadow_page[idx];
                2'd2: begin
                    page = shadow_page[idx];
                    page[IDX_W] = ~page[IDX_W];
                end
                default: page = rnd_low[31:32-hacd_pkg::PAGE_WIDTH];
            endcase
            attr = rnd_attr[$bits(hacd_pkg::ar_attr_t)-1:0];
            attr.len = {6'd0, rnd_attr[31:30]};
            if (rnd[31]) begin
                @(posedge clk);
                #1;
            end
            send_read(rnd[8 +: ID_WIDTH], {page, rnd_low[hacd_pkg::PAGE_SHIFT-1:0]}, attr);
        end
    endtask

    // Bridge idle and every burst returned
    task automatic drain();
        int waited;
        waited = 0;
        while (!timed_out && !(s_axi_arready && mem_addr_q.size() == 0)) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("Timeout at %0t waiting for outstanding reads to finish", $time);
            end
        end
    endtask

    // Memory model with random back-pressure on both sides
    initial begin
        logic [31:0] rnd;
        logic        beat_done;
        m_axi_arready = 1'b0;
        m_axi_rid = '0;
        m_axi_rdata = '0;
        m_axi_rresp = 2'b00;
        m_axi_rlast = 1'b0;
        m_axi_rvalid = 1'b0;
        s_axi_rready = 1'b0;
        mem_beat = 0;
        forever begin
            @(posedge clk);
            beat_done = m_axi_rvalid && m_axi_rready;
            if (m_axi_arvalid && m_axi_arready) begin
                mem_addr_q.push_back(m_axi_araddr);
                mem_id_q.push_back(m_axi_arid);
                mem_len_q.push_back(m_axi_arattr.len);
            end
            if (beat_done && m_axi_rlast) begin
                void'(mem_addr_q.pop_front());
                void'(mem_id_q.pop_front());
                void'(mem_len_q.pop_front());
                mem_beat = 0;
            end else if (beat_done) begin
                mem_beat++;
            end
            #1;
            rnd = $random(seed);
            m_axi_arready = rnd[0] | rnd[1];
            s_axi_rready = rnd[2] | rnd[3];
            if (beat_done || !m_axi_rvalid) begin
                m_axi_rvalid = (mem_addr_q.size() > 0) && rnd[4];
                if (mem_addr_q.size() > 0) begin
                    m_axi_rid = mem_id_q[0];
                    m_axi_rdata = DATA_WIDTH'(mem_addr_q[0]) + DATA_WIDTH'(mem_beat);
                    // Response code varies with the address and the beat
                    m_axi_rresp = mem_addr_q[0][1:0] + mem_beat[1:0];
                    m_axi_rlast = (mem_beat == mem_len_q[0]);
                end
            end
        end
    end

    initial begin
        int prop_fails;
        seed = 32'hc946_457c;
        timed_out = 1'b0;
        rst = 1'b1;
        hawk_enable = 1'b1;
        att_wr = '0;
        s_axi_arid = '0;
        s_axi_araddr = '0;
        s_axi_arattr = '0;
        s_axi_arvalid = 1'b0;
        exp_araddr = '0;
        exp_miss_count = '0;
        for (int i = 0; i < ATT_ENTRIES; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_page[i] = hacd_pkg::page_t'(i);
            shadow_ppa[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        drain();

        // Empty table right after reset so every lookup misses
        send_batch(6);
        drain();
        i_checker.check_miss_count();

        // Entries 0..7 valid and entry 8 written but marked invalid
        for (int i = 0; i < 9; i++) begin
            program_entry(i, i < 8);
        end
        send_batch(40);
        drain();
        i_checker.check_miss_count();

        hawk_enable = 1'b0;
        send_batch(20);
        drain();
        i_checker.check_miss_count();

        hawk_enable = 1'b1;
        send_batch(20);
        drain();
        i_checker.final_checks();
        #1;
        prop_fails = i_dut.i_stall_rd.i_bridge_props.fail_count +
                     i_dut.i_ctrl.i_ctrl_props.fail_count;
        i_checker.print_summary(prop_fails, timed_out);
        if (error_count == 0 && prop_fails == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verification/hacd_checker.sv ====
// Scoreboard for the page remapping read bridge
// Memory AR matched against CPU requests in order, R beats checked
// against the issued bursts, miss count and reset values compared

`timescale 1ns/1ps

module hacd_checker #(
    parameter int ID_WIDTH   = 4,
    parameter int DATA_WIDTH = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [ID_WIDTH-1:0]   s_axi_arid,
    input  hacd_pkg::ar_attr_t    s_axi_arattr,
    input  logic                  s_axi_arvalid,
    input  logic                  s_axi_arready,
    input  hacd_pkg::addr_t       exp_araddr,
    input  logic [ID_WIDTH-1:0]   m_axi_arid,
    input  hacd_pkg::addr_t       m_axi_araddr,
    input  hacd_pkg::ar_attr_t    m_axi_arattr,
    input  logic                  m_axi_arvalid,
    input  logic                  m_axi_arready,
    input  logic [ID_WIDTH-1:0]   s_axi_rid,
    input  logic [DATA_WIDTH-1:0] s_axi_rdata,
    input  logic [1:0]            s_axi_rresp,
    input  logic                  s_axi_rlast,
    input  logic                  s_axi_rvalid,
    input  logic                  s_axi_rready,
    input  hacd_pkg::miss_cnt_t   att_miss_count,
    input  hacd_pkg::miss_cnt_t   exp_miss_count,
    output int                    error_count
);

    int ar_errors = 0;
    int r_errors = 0;
    int other_errors = 0;
    int rd_beat = 0;

    // Requests accepted from the CPU with the expected memory address
    logic [ID_WIDTH-1:0] cpu_id_q[$];
    hacd_pkg::addr_t     cpu_addr_q[$];
    hacd_pkg::ar_attr_t  cpu_attr_q[$];

    // Bursts issued to memory and not yet fully returned
    logic [ID_WIDTH-1:0] rd_id_q[$];
    hacd_pkg::addr_t     rd_addr_q[$];
    logic [7:0]          rd_len_q[$];

    assign error_count = ar_errors + r_errors + other_errors;

    task automatic compare_field(input string name, input logic [63:0] exp,
                                 input logic [63:0] got, input int kind);
        if (got !== exp) begin
            $display("FAIL t=%0t %s expected=%h got=%h", $time, name, exp, got);
            if (kind == 0) begin
                ar_errors++;
            end else if (kind == 1) begin
                r_errors++;
            end else begin
                other_errors++;
            end
        end
    endtask

    task automatic score_beat();
        logic [DATA_WIDTH-1:0] exp_data;
        logic [1:0]            exp_resp;
        logic                  exp_last;
        if (rd_id_q.size() == 0) begin
            other_errors++;
            $display("Read beat at %0t with no burst outstanding", $time);
        end else begin
            // Memory data is the burst address plus the beat number
            exp_data = DATA_WIDTH'(rd_addr_q[0]) + DATA_WIDTH'(rd_beat);
            // Response code follows the low address bits plus the beat number
            exp_resp = rd_addr_q[0][1:0] + rd_beat[1:0];
            exp_last = (rd_beat == rd_len_q[0]);
            compare_field("s_axi_rid", rd_id_q[0], s_axi_rid, 1);
            compare_field("s_axi_rdata", exp_data, s_axi_rdata, 1);
            compare_field("s_axi_rresp", exp_resp, s_axi_rresp, 1);
            compare_field("s_axi_rlast", exp_last, s_axi_rlast, 1);
            if (exp_last) begin
                void'(rd_id_q.pop_front());
                void'(rd_addr_q.pop_front());
                void'(rd_len_q.pop_front());
                rd_beat = 0;
            end else begin
                rd_beat++;
            end
        end
    endtask

    // Reset values as reset is released
    always @(negedge rst) begin
        compare_field("s_axi_arready", 1'b0, s_axi_arready, 2);
        compare_field("m_axi_arvalid", 1'b0, m_axi_arvalid, 2);
        compare_field("att_miss_count", 16'd0, att_miss_count, 2);
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (s_axi_arvalid && s_axi_arready) begin
                cpu_id_q.push_back(s_axi_arid);
                cpu_addr_q.push_back(exp_araddr);
                cpu_attr_q.push_back(s_axi_arattr);
            end
            if (m_axi_arvalid && m_axi_arready) begin
                if (cpu_id_q.size() == 0) begin
                    other_errors++;
                    $display("Memory request at %0t with no CPU request pending", $time);
                end else begin
                    compare_field("m_axi_arid", cpu_id_q.pop_front(), m_axi_arid, 0);
                    compare_field("m_axi_araddr", cpu_addr_q.pop_front(), m_axi_araddr, 0);
                    compare_field("m_axi_arattr", cpu_attr_q.pop_front(), m_axi_arattr, 0);
                end
                rd_id_q.push_back(m_axi_arid);
                rd_addr_q.push_back(m_axi_araddr);
                rd_len_q.push_back(m_axi_arattr.len);
            end
            if (s_axi_rvalid && s_axi_rready) begin
                score_beat();
            end
        end
    end

    task automatic check_miss_count();
        compare_field("att_miss_count", exp_miss_count, att_miss_count, 2);
    endtask

    task automatic final_checks();
        check_miss_count();
        if (cpu_id_q.size() != 0 || rd_id_q.size() != 0) begin
            other_errors++;
            $display("CPU requests or read bursts still outstanding at the end of the run");
        end
    endtask

    task automatic print_summary(input int prop_fails, input bit timed_out);
        $display("Errors: %0d AR, %0d R, %0d other, %0d assertion, timeout %0d",
                 ar_errors, r_errors, other_errors, prop_fails, timed_out);
    endtask

endmodule

// ==== verification/hacd_properties.sv ====
// Concurrent assertions on the bridge and control handshakes
// Bound into hawk_cpu_stall_rd and hawk_ctrl

`timescale 1ns/1ps

module hacd_properties (
    input logic clk,
    input logic rst,
    input logic allow_access,
    input logic req_held,
    input logic s_arready,
    input logic m_arvalid,
    input logic m_arready
);

    int fail_count = 0;

    // Permission is a single-cycle strobe
    allow_single_cycle: assert property (
        @(posedge clk) disable iff (rst) allow_access |=> !allow_access
    ) else begin
        fail_count++;
        $error("allow_access stayed high for more than one cycle");
    end

    arvalid_held: assert property (
        @(posedge clk) disable iff (rst) (m_arvalid && !m_arready) |=> m_arvalid
    ) else begin
        fail_count++;
        $error("m_axi_arvalid dropped before m_axi_arready");
    end

    // Only one request in the bridge at a time
    no_accept_while_held: assert property (
        @(posedge clk) disable iff (rst) (req_held || m_arvalid) |-> !s_arready
    ) else begin
        fail_count++;
        $error("s_axi_arready high while a request is held");
    end

endmodule

bind hawk_cpu_stall_rd hacd_properties i_bridge_props (
    .clk          (clk),
    .rst          (rst),
    .allow_access (hawk_cpu_ovrd_pkt.allow_access),
    .req_held     (state == hacd_pkg::RD_WAIT),
    .s_arready    (s_axi_arready),
    .m_arvalid    (m_axi_arvalid),
    .m_arready    (m_axi_arready)
);

bind hawk_ctrl hacd_properties i_ctrl_props (
    .clk          (clk),
    .rst          (rst),
    .allow_access (hawk_cpu_ovrd_pkt.allow_access),
    .req_held     (1'b0),
    .s_arready    (1'b0),
    .m_arvalid    (1'b0),
    .m_arready    (1'b1)
);

// ==== rtl/hacd_top.sv ====
// Top level of the read bridge with page remapping
// Connects the stall bridge, the control unit and the translation table

`timescale 1ns/1ps

module hacd_top #(
    parameter int ID_WIDTH    = 4,
    parameter int DATA_WIDTH  = 64,
    parameter int ATT_ENTRIES = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  hawk_enable,
    input  hacd_pkg::att_wr_t     att_wr,
    output hacd_pkg::miss_cnt_t   att_miss_count,

    input  logic [ID_WIDTH-1:0]   s_axi_arid,
    input  hacd_pkg::addr_t       s_axi_araddr,
    input  hacd_pkg::ar_attr_t    s_axi_arattr,
    input  logic                  s_axi_arvalid,
    output logic                  s_axi_arready,
    output logic [ID_WIDTH-1:0]   s_axi_rid,
    output logic [DATA_WIDTH-1:0] s_axi_rdata,
    output logic [1:0]            s_axi_rresp,
    output logic                  s_axi_rlast,
    output logic                  s_axi_rvalid,
    input  logic                  s_axi_rready,

    output logic [ID_WIDTH-1:0]   m_axi_arid,
    output hacd_pkg::addr_t       m_axi_araddr,
    output hacd_pkg::ar_attr_t    m_axi_arattr,
    output logic                  m_axi_arvalid,
    input  logic                  m_axi_arready,
    input  logic [ID_WIDTH-1:0]   m_axi_rid,
    input  logic [DATA_WIDTH-1:0] m_axi_rdata,
    input  logic [1:0]            m_axi_rresp,
    input  logic                  m_axi_rlast,
    input  logic                  m_axi_rvalid,
    output logic                  m_axi_rready
);

    hacd_pkg::cpu_reqpkt_t        cpu_reqpkt;
    hacd_pkg::hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_pkt;
    hacd_pkg::page_t              lookup_page;
    hacd_pkg::att_rsp_t           att_rsp;
    logic                         hawk_inactive;
    logic                         lookup_vld;

    hawk_cpu_stall_rd #(
        .ID_WIDTH   (ID_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) i_stall_rd (
        .clk               (clk),
        .rst               (rst),
        .hawk_cpu_ovrd_pkt (hawk_cpu_ovrd_pkt),
        .cpu_reqpkt        (cpu_reqpkt),
        .hawk_inactive     (hawk_inactive),
        .s_axi_arid        (s_axi_arid),
        .s_axi_araddr      (s_axi_araddr),
        .s_axi_arattr      (s_axi_arattr),
        .s_axi_arvalid     (s_axi_arvalid),
        .s_axi_arready     (s_axi_arready),
        .s_axi_rid         (s_axi_rid),
        .s_axi_rdata       (s_axi_rdata),
        .s_axi_rresp       (s_axi_rresp),
        .s_axi_rlast       (s_axi_rlast),
        .s_axi_rvalid      (s_axi_rvalid),
        .s_axi_rready      (s_axi_rready),
        .m_axi_arid        (m_axi_arid),
        .m_axi_araddr      (m_axi_araddr),
        .m_axi_arattr      (m_axi_arattr),
        .m_axi_arvalid     (m_axi_arvalid),
        .m_axi_arready     (m_axi_arready),
        .m_axi_rid         (m_axi_rid),
        .m_axi_rdata       (m_axi_rdata),
        .m_axi_rresp       (m_axi_rresp),
        .m_axi_rlast       (m_axi_rlast),
        .m_axi_rvalid      (m_axi_rvalid),
        .m_axi_rready      (m_axi_rready)
    );

    hawk_ctrl i_ctrl (
        .clk               (clk),
        .rst               (rst),
        .hawk_enable       (hawk_enable),
        .cpu_reqpkt        (cpu_reqpkt),
        .hawk_cpu_ovrd_pkt (hawk_cpu_ovrd_pkt),
        .hawk_inactive     (hawk_inactive),
        .lookup_vld        (lookup_vld),
        .lookup_page       (lookup_page),
        .att_rsp           (att_rsp),
        .att_miss_count    (att_miss_count)
    );

    hawk_att_table #(
        .ATT_ENTRIES (ATT_ENTRIES)
    ) i_att_table (
        .clk         (clk),
        .rst         (rst),
        .att_wr      (att_wr),
        .lookup_vld  (lookup_vld),
        .lookup_page (lookup_page),
        .att_rsp     (att_rsp)
    );

endmodule

// ==== rtl/hawk_ctrl.sv ====
// Control unit serving bridge lookup requests
// Drives the table lookup, returns the allow strobe with the physical page
// and counts table misses

`timescale 1ns/1ps

module hawk_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         hawk_enable,
    input  hacd_pkg::cpu_reqpkt_t        cpu_reqpkt,
    output hacd_pkg::hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_pkt,
    output logic                         hawk_inactive,
    output logic                         lookup_vld,
    output hacd_pkg::page_t              lookup_page,
    input  hacd_pkg::att_rsp_t           att_rsp,
    output hacd_pkg::miss_cnt_t          att_miss_count
);

    hacd_pkg::ctrl_state_t state, state_next;

    hacd_pkg::page_t     req_page_q;
    hacd_pkg::page_t     ppa_q;
    hacd_pkg::miss_cnt_t miss_cnt_q;
    logic                respond;

    always_comb begin
        state_next = state;
        case (state)
            hacd_pkg::CTRL_IDLE: begin
                if (hawk_enable && cpu_reqpkt.valid) begin
                    state_next = hacd_pkg::CTRL_LOOKUP;
                end
            end
            hacd_pkg::CTRL_LOOKUP:  state_next = hacd_pkg::CTRL_RESPOND;
            hacd_pkg::CTRL_RESPOND: state_next = hacd_pkg::CTRL_IDLE;
            default:                state_next = hacd_pkg::CTRL_IDLE;
        endcase
        // Disabling abandons any lookup in flight
        if (!hawk_enable) begin
            state_next = hacd_pkg::CTRL_IDLE;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= hacd_pkg::CTRL_IDLE;
            miss_cnt_q <= '0;
        end else begin
            state <= state_next;
            // Saturating miss counter
            if (respond && !att_rsp.hit && (miss_cnt_q != '1)) begin
                miss_cnt_q <= miss_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == hacd_pkg::CTRL_IDLE) && cpu_reqpkt.valid) begin
            req_page_q <= cpu_reqpkt.hppa;
        end
        // A miss maps the page to itself
        if (respond) begin
            ppa_q <= att_rsp.hit ? att_rsp.ppa : req_page_q;
        end
    end

    assign respond = (state == hacd_pkg::CTRL_RESPOND) && hawk_enable;

    assign lookup_vld  = (state == hacd_pkg::CTRL_LOOKUP);
    assign lookup_page = req_page_q;

    assign hawk_inactive = !hawk_enable;
    assign hawk_cpu_ovrd_pkt.allow_access = respond;
    assign hawk_cpu_ovrd_pkt.ppa = hawk_enable ? ppa_q : cpu_reqpkt.hppa;

    assign att_miss_count = miss_cnt_q;

endmodule

// ==== rtl/hawk_att_table.sv ====
// Direct-mapped address translation table
// One-cycle programming port and a registered lookup port

`timescale 1ns/1ps

module hawk_att_table #(
    parameter int ATT_ENTRIES = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  hacd_pkg::att_wr_t   att_wr,
    input  logic                lookup_vld,
    input  hacd_pkg::page_t     lookup_page,
    output hacd_pkg::att_rsp_t  att_rsp
);

    localparam int IDX_W = $clog2(ATT_ENTRIES);
    localparam int TAG_W = hacd_pkg::PAGE_WIDTH - IDX_W;

    // Entry storage
    logic [ATT_ENTRIES-1:0] entry_vld_q;
    logic [TAG_W-1:0]       tag_mem [ATT_ENTRIES];
    hacd_pkg::page_t        ppa_mem [ATT_ENTRIES];

    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;

    logic            hit_q;
    hacd_pkg::page_t rsp_ppa_q;

    assign wr_idx = att_wr.page[IDX_W-1:0];
    assign wr_tag = att_wr.page[hacd_pkg::PAGE_WIDTH-1:IDX_W];
    assign rd_idx = lookup_page[IDX_W-1:0];
    assign rd_tag = lookup_page[hacd_pkg::PAGE_WIDTH-1:IDX_W];

    // Valid bits start cleared so every page misses after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entry_vld_q <= '0;
        end else if (att_wr.valid) begin
            entry_vld_q[wr_idx] <= att_wr.entry_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (att_wr.valid) begin
            tag_mem[wr_idx] <= wr_tag;
            ppa_mem[wr_idx] <= att_wr.ppa;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit_q <= 1'b0;
        end else if (lookup_vld) begin
            hit_q <= entry_vld_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_vld) begin
            rsp_ppa_q <= ppa_mem[rd_idx];
        end
    end

    assign att_rsp.hit = hit_q;
    assign att_rsp.ppa = rsp_ppa_q;

endmodule

// ==== rtl/hawk_cpu_stall_rd.sv ====
// AXI4 read address stall bridge
// Holds one CPU read request until the control unit allows it,
// then issues it to memory with the page number substituted.
// R channel is a straight pass-through.

`timescale 1ns/1ps

module hawk_cpu_stall_rd #(
    parameter int ID_WIDTH   = 4,
    parameter int DATA_WIDTH = 64
) (
    input  logic                        clk,
    input  logic                        rst,

    // Control unit side
    input  hacd_pkg::hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_pkt,
    output hacd_pkg::cpu_reqpkt_t       cpu_reqpkt,
    input  logic                        hawk_inactive,

    // CPU read address
    input  logic [ID_WIDTH-1:0]         s_axi_arid,
    input  hacd_pkg::addr_t             s_axi_araddr,
    input  hacd_pkg::ar_attr_t          s_axi_arattr,
    input  logic                        s_axi_arvalid,
    output logic                        s_axi_arready,

    // CPU read data
    output logic [ID_WIDTH-1:0]         s_axi_rid,
    output logic [DATA_WIDTH-1:0]       s_axi_rdata,
    output logic [1:0]                  s_axi_rresp,
    output logic                        s_axi_rlast,
    output logic                        s_axi_rvalid,
    input  logic                        s_axi_rready,

    // Memory read address
    output logic [ID_WIDTH-1:0]         m_axi_arid,
    output hacd_pkg::addr_t             m_axi_araddr,
    output hacd_pkg::ar_attr_t          m_axi_arattr,
    output logic                        m_axi_arvalid,
    input  logic                        m_axi_arready,

    // Memory read data
    input  logic [ID_WIDTH-1:0]         m_axi_rid,
    input  logic [DATA_WIDTH-1:0]       m_axi_rdata,
    input  logic [1:0]                  m_axi_rresp,
    input  logic                        m_axi_rlast,
    input  logic                        m_axi_rvalid,
    output logic                        m_axi_rready
);

    hacd_pkg::rd_state_t state, state_next;

    logic s_arready_q, s_arready_next;
    logic m_arvalid_q, m_arvalid_next;
    logic allow_q, allow_next;
    logic capture;
    logic issue;

    // Held request
    logic [ID_WIDTH-1:0] req_id_q;
    hacd_pkg::addr_t     req_addr_q;
    hacd_pkg::ar_attr_t  req_attr_q;
    hacd_pkg::addr_t     m_araddr_q;

    always_comb begin
        state_next     = state;
        s_arready_next = 1'b0;
        m_arvalid_next = m_arvalid_q && !m_axi_arready;
        allow_next     = 1'b0;
        capture        = 1'b0;
        issue          = 1'b0;
        case (state)
            hacd_pkg::RD_IDLE: begin
                // Reopen only once the previous request left for memory
                s_arready_next = !m_arvalid_q;
                if (s_axi_arvalid && s_arready_q) begin
                    s_arready_next = 1'b0;
                    capture        = 1'b1;
                    state_next     = hacd_pkg::RD_WAIT;
                end
            end
            hacd_pkg::RD_WAIT: begin
                allow_next = allow_q || hawk_cpu_ovrd_pkt.allow_access;
                if (allow_q || hawk_inactive) begin
                    issue          = 1'b1;
                    m_arvalid_next = 1'b1;
                    allow_next     = 1'b0;
                    state_next     = hacd_pkg::RD_IDLE;
                end
            end
            default: state_next = hacd_pkg::RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= hacd_pkg::RD_IDLE;
            s_arready_q <= 1'b0;
            m_arvalid_q <= 1'b0;
            allow_q     <= 1'b0;
        end else begin
            state       <= state_next;
            s_arready_q <= s_arready_next;
            m_arvalid_q <= m_arvalid_next;
            allow_q     <= allow_next;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            req_id_q   <= s_axi_arid;
            req_addr_q <= s_axi_araddr;
            req_attr_q <= s_axi_arattr;
        end
        // Page bits from the control unit with the offset kept
        if (issue) begin
            m_araddr_q <= {hawk_cpu_ovrd_pkt.ppa, req_addr_q[hacd_pkg::PAGE_SHIFT-1:0]};
        end
    end

    assign s_axi_arready = s_arready_q;
    assign m_axi_arvalid = m_arvalid_q;
    assign m_axi_arid    = req_id_q;
    assign m_axi_arattr  = req_attr_q;
    assign m_axi_araddr  = m_araddr_q;

    // Lookup stays requested until permission is seen
    assign cpu_reqpkt.valid = (state == hacd_pkg::RD_WAIT) &&
                              !(hawk_cpu_ovrd_pkt.allow_access || allow_q);
    assign cpu_reqpkt.hppa  = req_addr_q[hacd_pkg::ADDR_WIDTH-1:hacd_pkg::PAGE_SHIFT];

    assign m_axi_rready = s_axi_rready;
    assign s_axi_rid    = m_axi_rid;
    assign s_axi_rdata  = m_axi_rdata;
    assign s_axi_rresp  = m_axi_rresp;
    assign s_axi_rlast  = m_axi_rlast;
    assign s_axi_rvalid = m_axi_rvalid;

endmodule

// ==== rtl/hacd_pkg.sv ====
// Shared definitions for the page remapping read bridge
// Address and page widths, table types, bridge/control/table packets
// and the state encodings of the bridge and the control unit

package hacd_pkg;

    // Physical address and page geometry
    localparam int ADDR_WIDTH = 40;
    localparam int PAGE_SHIFT = 12;
    localparam int PAGE_WIDTH = ADDR_WIDTH - PAGE_SHIFT;
    localparam int MISS_CNT_WIDTH = 16;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [PAGE_WIDTH-1:0] page_t;
    typedef logic [MISS_CNT_WIDTH-1:0] miss_cnt_t;

    // AR attributes forwarded unchanged (29 bits)
    typedef struct packed {
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
        logic       lock;
        logic [3:0] cache;
        logic [2:0] prot;
        logic [3:0] qos;
        logic [3:0] region;
    } ar_attr_t;

    // Lookup request, bridge to control
    typedef struct packed {
        logic  valid;
        page_t hppa;
    } cpu_reqpkt_t;

    // Permission and physical page, control to bridge
    typedef struct packed {
        logic  allow_access;
        page_t ppa;
    } hawk_cpu_ovrd_pkt_t;

    // Table programming strobe with the index taken from the low page bits
    typedef struct packed {
        logic  valid;
        logic  entry_valid;
        page_t page;
        page_t ppa;
    } att_wr_t;

    // Registered lookup result
    typedef struct packed {
        logic  hit;
        page_t ppa;
    } att_rsp_t;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_LOOKUP,
        CTRL_RESPOND
    } ctrl_state_t;

    typedef enum logic {
        RD_IDLE,
        RD_WAIT
    } rd_state_t;

endpackage
